/* filelist.f */
common/mist_ctrl_pkg.sv
user_io/spi_bit_counter.sv
user_io/spi_cmd_fsm.sv
source/payload_reg.sv
source/key_map.sv
source/ctrl_top.sv
test/ctrl_tb.sv

/* Bender.yml */
package:
  name: mist_ctrl

sources:
  - files:
      - common/mist_ctrl_pkg.sv
  - files:
      - user_io/spi_bit_counter.sv
      - user_io/spi_cmd_fsm.sv
      - source/payload_reg.sv
      - source/key_map.sv
      - source/ctrl_top.sv
  - target: test
    files:
      - test/ctrl_tb.sv

/* test/ctrl_tb.sv */
`timescale 1ns/100ps

module ctrl_tb;
	import mist_ctrl_pkg::*;

	localparam int clk_period      = 20;
	localparam int n_joy           = 40;
	localparam int n_kbd           = 40;
	localparam int n_stat          = 30;
	localparam int n_btn           = 20;
	localparam int n_rob           = 30;
	localparam int max_frame_bytes = 7;
	localparam int frame_cycles    = max_frame_bytes * 64 + 32; // 8 bits of 8 clocks plus gaps
	localparam int n_frames        = n_joy + n_kbd + n_stat + 2 * n_btn + n_rob;

	logic       clk_mist;
	logic       rst;
	logic       spi_sck;
	logic       spi_ss;
	logic       spi_di;
	logic       m_up;
	logic       m_down;
	logic       m_left;
	logic       m_right;
	logic       m_fire;
	logic       m_bomb;
	logic       coin;
	logic       one_player;
	logic       two_players;
	logic       game_rst;
	logic [1:0] scanlines;

	// reference model state
	status_t  model_status;
	buttons_t model_buttons;
	joy_t     model_joy0;
	joy_t     model_joy1;
	kbd_btn_t model_keys;
	logic     model_release;

	byte_t       tx_q[$];
	byte_t       key_pool [0:13];
	int          err_count;
	int          test_err;
	int          tests_run;
	int          tests_ok;
	int          n;

	ctrl_top DUT (.clk_mist, .rst, .spi_sck, .spi_ss, .spi_di,
		.m_up, .m_down, .m_left, .m_right, .m_fire, .m_bomb,
		.coin, .one_player, .two_players, .game_rst, .scanlines);

	always #(clk_period / 2) clk_mist = ~clk_mist;

	task automatic compare_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERR %s exp %h got %h at %0t", name, exp, got, $time);
			err_count++;
		end
	endtask

	task automatic check_ctrl(input kbd_btn_t exp, input kbd_btn_t got);
		compare_bit("m_up", exp.up, got.up);
		compare_bit("m_down", exp.down, got.down);
		compare_bit("m_left", exp.left, got.left);
		compare_bit("m_right", exp.right, got.right);
		compare_bit("m_fire", exp.fire1, got.fire1);
		compare_bit("m_bomb", exp.fire2, got.fire2);
		compare_bit("coin", exp.coin, got.coin);
		compare_bit("one_player", exp.one_player, got.one_player);
		compare_bit("two_players", exp.two_players, got.two_players);
	endtask

	task automatic check_bits(input logic exp_rst, input logic [1:0] exp_scan,
		input logic got_rst, input logic [1:0] got_scan);
		compare_bit("game_rst", exp_rst, got_rst);
		if (got_scan !== exp_scan) begin
			$display("ERR scanlines exp %h got %h at %0t", exp_scan, got_scan, $time);
			err_count++;
		end
	endtask

	function automatic kbd_btn_t dut_ctrl();
		kbd_btn_t b;
		b             = '0;
		b.up          = m_up;
		b.down        = m_down;
		b.left        = m_left;
		b.right       = m_right;
		b.fire1       = m_fire;
		b.fire2       = m_bomb;
		b.coin        = coin;
		b.one_player  = one_player;
		b.two_players = two_players;
		return b;
	endfunction

	function automatic kbd_btn_t expected_ctrl();
		kbd_btn_t e;
		e             = '0;
		e.up          = model_keys.up | model_joy0[3] | model_joy1[3];
		e.down        = model_keys.down | model_joy0[2] | model_joy1[2];
		e.left        = model_keys.left | model_joy0[1] | model_joy1[1];
		e.right       = model_keys.right | model_joy0[0] | model_joy1[0];
		e.fire1       = model_keys.fire1 | model_joy0[4] | model_joy1[4];
		e.fire2       = model_keys.fire2 | model_joy0[5] | model_joy1[5];
		e.coin        = model_keys.coin;
		e.one_player  = model_keys.one_player;
		e.two_players = model_keys.two_players;
		return e;
	endfunction

	task automatic apply_key(input byte_t code);
		if (code == sc_break) begin
			model_release = 1'b1;
		end else if (code != sc_ext) begin
			case (code)
				sc_up:    model_keys.up          = !model_release;
				sc_down:  model_keys.down        = !model_release;
				sc_left:  model_keys.left        = !model_release;
				sc_right: model_keys.right       = !model_release;
				sc_esc:   model_keys.coin        = !model_release;
				sc_f1:    model_keys.one_player  = !model_release;
				sc_f2:    model_keys.two_players = !model_release;
				sc_space: model_keys.fire1       = !model_release;
				sc_alt:   model_keys.fire2       = !model_release;
				sc_ctrl:  model_keys.fire3       = !model_release;
				default:  ;
			endcase
			model_release = 1'b0;
		end
	endtask

	// command byte first then payload from index 0
	task automatic apply_frame();
		byte_t cmd;
		int    i;
		cmd = tx_q[0];
		for (i = 1; i < tx_q.size(); i++) begin
			case (cmd)
				cmd_status:  if (i - 1 < status_bytes) model_status[8*(i-1) +: 8] = tx_q[i];
				cmd_buttons: if (i == 1) model_buttons = tx_q[i];
				cmd_joy0:    if (i == 1) model_joy0 = tx_q[i];
				cmd_joy1:    if (i == 1) model_joy1 = tx_q[i];
				cmd_ps2_kbd: apply_key(tx_q[i]);
				default:     ;
			endcase
		end
	endtask

	task automatic send_byte(input byte_t b);
		int i;
		for (i = 7; i >= 0; i--) begin
			spi_sck <= 1'b0;
			spi_di  <= b[i]; // msb first
			repeat (4) @(posedge clk_mist);
			spi_sck <= 1'b1;
			repeat (4) @(posedge clk_mist);
		end
	endtask

	task automatic send_frame();
		@(posedge clk_mist);
		spi_ss <= 1'b0;
		repeat (4) @(posedge clk_mist);
		foreach (tx_q[i])
			send_byte(tx_q[i]);
		spi_sck <= 1'b0;
		repeat (4) @(posedge clk_mist);
		spi_ss <= 1'b1;
		repeat (8) @(posedge clk_mist); // settle
		@(negedge clk_mist);
		apply_frame();
		check_ctrl(expected_ctrl(), dut_ctrl());
		check_bits(model_status[status_rst_bit] | model_status[status_rst2_bit]
			| model_buttons[btn_rst_bit], model_status[scan_hi:scan_lo], game_rst, scanlines);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_count == test_err) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d mismatches", name, err_count - test_err);
		end
		test_err = err_count;
	endtask

	function automatic byte_t pick_key();
		int k;
		k = $urandom_range(0, 14);
		if (k == 14)
			return byte_t'($urandom); // any code
		return key_pool[k];
	endfunction

	function automatic logic is_known(input byte_t c);
		return c == cmd_status || c == cmd_buttons || c == cmd_joy0 || c == cmd_joy1
			|| c == cmd_ps2_kbd;
	endfunction

	function automatic byte_t unknown_cmd();
		byte_t c;
		c = byte_t'($urandom);
		while (is_known(c))
			c = byte_t'($urandom);
		return c;
	endfunction

	initial begin
		#(n_frames * frame_cycles * clk_period + 200 * clk_period);
		$display("timeout, the run did not finish in time");
		$display("tests failed");
		$finish;
	end

	initial begin
		clk_mist      = 1'b0;
		rst           = 1'b1;
		spi_sck       = 1'b0;
		spi_ss        = 1'b1;
		spi_di        = 1'b0;
		err_count     = 0;
		test_err      = 0;
		tests_run     = 0;
		tests_ok      = 0;
		model_status  = '0;
		model_buttons = '0;
		model_joy0    = '0;
		model_joy1    = '0;
		model_keys    = '0;
		model_release = 1'b0;
		void'($urandom(32'h6652bacb));
		key_pool      = '{sc_up, sc_down, sc_left, sc_right, sc_esc, sc_f1, sc_f2,
			sc_ctrl, sc_alt, sc_space, sc_break, sc_break, sc_ext, 8'h1C};

		repeat (2) @(posedge clk_mist);
		rst <= 1'b0;
		repeat (4) @(posedge clk_mist);
		@(negedge clk_mist);
		check_ctrl('0, dut_ctrl());
		check_bits(1'b0, 2'b00, game_rst, scanlines);
		finish_test("reset state");

		repeat (n_joy) begin
			tx_q.delete();
			tx_q.push_back($urandom_range(0, 1) ? cmd_joy1 : cmd_joy0);
			tx_q.push_back(byte_t'($urandom));
			send_frame();
		end
		finish_test("joystick merge");

		repeat (n_kbd) begin
			tx_q.delete();
			tx_q.push_back(cmd_ps2_kbd);
			n = $urandom_range(1, 5);
			repeat (n) tx_q.push_back(pick_key());
			send_frame();
		end
		finish_test("keyboard mapping");

		repeat (n_stat) begin
			tx_q.delete();
			tx_q.push_back(cmd_status);
			n = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 4; // some cut short
			repeat (n) tx_q.push_back(byte_t'($urandom));
			send_frame();
		end
		finish_test("status word");

		repeat (n_btn) begin
			tx_q.delete();
			tx_q.push_back(cmd_buttons);
			tx_q.push_back(byte_t'($urandom));
			send_frame();
			tx_q.delete();
			tx_q.push_back(cmd_status);
			tx_q.push_back(byte_t'($urandom)); // low lane only
			send_frame();
		end
		finish_test("buttons and reset");

		repeat (n_rob) begin
			tx_q.delete();
			case ($urandom_range(0, 2))
				0: begin
					tx_q.push_back(unknown_cmd());
					n = $urandom_range(0, 5);
				end
				1: begin
					tx_q.push_back(byte_t'($urandom_range(1, 3))); // buttons or a joystick
					n = $urandom_range(2, 5);
				end
				default: begin
					tx_q.push_back(cmd_status);
					n = $urandom_range(5, 6);
				end
			endcase
			repeat (n) tx_q.push_back(byte_t'($urandom));
			send_frame();
		end
		finish_test("robustness");

		$display("%0d of %0d tests ok, %0d mismatches", tests_ok, tests_run, err_count);
		if (err_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* source/ctrl_top.sv */
`timescale 1ns/100ps

module ctrl_top (
	input  logic       clk_mist,
	input  logic       rst,
	input  logic       spi_sck,
	input  logic       spi_ss,
	input  logic       spi_di,
	output logic       m_up,
	output logic       m_down,
	output logic       m_left,
	output logic       m_right,
	output logic       m_fire,
	output logic       m_bomb,
	output logic       coin,
	output logic       one_player,
	output logic       two_players,
	output logic       game_rst,
	output logic [1:0] scanlines
);
	import mist_ctrl_pkg::*;

	logic             byte_done;
	byte_t            rx_byte;
	logic [idx_w-1:0] byte_idx;
	logic             frame_active;
	logic             status_we;
	logic             buttons_we;
	logic             joy0_we;
	logic             joy1_we;
	logic [1:0]       lane;
	byte_t            wr_byte;
	logic             key_strobe;
	byte_t            key_code;
	status_t          status;
	buttons_t         buttons;
	joy_t             joy0;
	joy_t             joy1;
	kbd_btn_t         keys;

	spi_bit_counter u_bits (.clk_mist, .rst, .spi_sck, .spi_ss, .spi_di,
		.byte_done, .rx_byte, .byte_idx, .frame_active);

	spi_cmd_fsm u_fsm (.clk_mist, .rst, .byte_done, .rx_byte, .byte_idx, .frame_active,
		.status_we, .buttons_we, .joy0_we, .joy1_we, .lane, .wr_byte,
		.key_strobe, .key_code);

	payload_reg #(.payload_t(status_t)) u_status (.clk_mist, .rst, .we(status_we),
		.lane, .wr_byte, .value(status));
	payload_reg #(.payload_t(buttons_t)) u_buttons (.clk_mist, .rst, .we(buttons_we),
		.lane, .wr_byte, .value(buttons));
	payload_reg #(.payload_t(joy_t)) u_joy0 (.clk_mist, .rst, .we(joy0_we),
		.lane, .wr_byte, .value(joy0));
	payload_reg #(.payload_t(joy_t)) u_joy1 (.clk_mist, .rst, .we(joy1_we),
		.lane, .wr_byte, .value(joy1));

	key_map u_keys (.clk_mist, .rst, .key_strobe, .key_code, .keys);

	// keyboard or either joystick
	assign m_up        = keys.up    | joy0[3] | joy1[3];
	assign m_down      = keys.down  | joy0[2] | joy1[2];
	assign m_left      = keys.left  | joy0[1] | joy1[1];
	assign m_right     = keys.right | joy0[0] | joy1[0];
	assign m_fire      = keys.fire1 | joy0[4] | joy1[4];
	assign m_bomb      = keys.fire2 | joy0[5] | joy1[5];
	assign coin        = keys.coin;
	assign one_player  = keys.one_player;
	assign two_players = keys.two_players;

	assign game_rst  = status[status_rst_bit] | status[status_rst2_bit] | buttons[btn_rst_bit];
	assign scanlines = status[scan_hi:scan_lo]; // off, 25, 50, 75 percent

endmodule

/* source/key_map.sv */
`timescale 1ns/100ps

module key_map (
	input  logic                     clk_mist,
	input  logic                     rst,
	input  logic                     key_strobe,
	input  mist_ctrl_pkg::byte_t     key_code,
	output mist_ctrl_pkg::kbd_btn_t  keys
);
	import mist_ctrl_pkg::*;

	logic release_q;
	logic pressed;

	assign pressed = ~release_q;

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			release_q <= 1'b0;
			keys      <= '0;
		end else if (key_strobe) begin
			if (key_code == sc_break) begin
				release_q <= 1'b1;
			end else if (key_code != sc_ext) begin // e0 keeps the flag
				release_q <= 1'b0;
				case (key_code)
					sc_up:    keys.up          <= pressed;
					sc_down:  keys.down        <= pressed;
					sc_left:  keys.left        <= pressed;
					sc_right: keys.right       <= pressed;
					sc_esc:   keys.coin        <= pressed;
					sc_f1:    keys.one_player  <= pressed;
					sc_f2:    keys.two_players <= pressed;
					sc_ctrl:  keys.fire3       <= pressed;
					sc_alt:   keys.fire2       <= pressed;
					sc_space: keys.fire1       <= pressed;
					default:  ; // unmapped
				endcase
			end
		end
	end

endmodule

/* source/payload_reg.sv */
`timescale 1ns/100ps

module payload_reg #(
	parameter type payload_t = mist_ctrl_pkg::byte_t
) (
	input  logic                 clk_mist,
	input  logic                 rst,
	input  logic                 we,
	input  logic [1:0]           lane,
	input  mist_ctrl_pkg::byte_t wr_byte,
	output payload_t             value
);
	localparam int n_lanes = $bits(payload_t) / 8;

	logic [$bits(payload_t)-1:0] value_q;

	always_ff @(posedge clk_mist) begin
		if (rst)
			value_q <= '0;
		else if (we)
			value_q[8*lane +: 8] <= wr_byte; // lane 0 is the low byte
	end

	assign value = payload_t'(value_q);

	a_lane_range: assert property (@(posedge clk_mist) disable iff (rst)
		we |-> int'(lane) < n_lanes);

endmodule

/* user_io/spi_cmd_fsm.sv */
`timescale 1ns/100ps

module spi_cmd_fsm (
	input  logic                              clk_mist,
	input  logic                              rst,
	input  logic                              byte_done,
	input  mist_ctrl_pkg::byte_t              rx_byte,
	input  logic [mist_ctrl_pkg::idx_w-1:0]   byte_idx,
	input  logic                              frame_active,
	output logic                              status_we,
	output logic                              buttons_we,
	output logic                              joy0_we,
	output logic                              joy1_we,
	output logic [1:0]                        lane,
	output mist_ctrl_pkg::byte_t              wr_byte,
	output logic                              key_strobe,
	output mist_ctrl_pkg::byte_t              key_code
);
	import mist_ctrl_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_cmd,
		st_payload,
		st_drop
	} state_t;

	state_t           state;
	byte_t            cmd_q;
	logic [idx_w-1:0] pay_idx;
	logic             in_range;

	// payload length in bytes or zero for unknown commands
	function automatic logic [idx_w-1:0] cmd_len(input byte_t c);
		case (c)
			cmd_status:  return idx_w'(status_bytes);
			cmd_buttons: return idx_w'(1);
			cmd_joy0:    return idx_w'(1);
			cmd_joy1:    return idx_w'(1);
			default:     return '0;
		endcase
	endfunction

	assign pay_idx  = byte_idx - 1'b1; // first byte was the command
	assign in_range = (cmd_q == cmd_ps2_kbd) || (pay_idx < cmd_len(cmd_q));

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			state      <= st_idle;
			cmd_q      <= '0;
			status_we  <= 1'b0;
			buttons_we <= 1'b0;
			joy0_we    <= 1'b0;
			joy1_we    <= 1'b0;
			key_strobe <= 1'b0;
		end else begin
			status_we  <= 1'b0;
			buttons_we <= 1'b0;
			joy0_we    <= 1'b0;
			joy1_we    <= 1'b0;
			key_strobe <= 1'b0;
			if (!frame_active) begin
				state <= st_idle;
			end else begin
				case (state)
					st_idle: state <= st_cmd;
					st_cmd: if (byte_done) begin
						cmd_q <= rx_byte;
						if (cmd_len(rx_byte) != '0 || rx_byte == cmd_ps2_kbd)
							state <= st_payload;
						else
							state <= st_drop; // unknown command
					end
					st_payload: if (byte_done) begin
						if (in_range) begin
							case (cmd_q)
								cmd_status:  status_we  <= 1'b1;
								cmd_buttons: buttons_we <= 1'b1;
								cmd_joy0:    joy0_we    <= 1'b1;
								cmd_joy1:    joy1_we    <= 1'b1;
								default:     key_strobe <= 1'b1;
							endcase
						end else begin
							state <= st_drop;
						end
					end
					default: ; // drop until ss rises
				endcase
			end
		end
	end

	always_ff @(posedge clk_mist) begin
		if (byte_done) begin
			wr_byte  <= rx_byte;
			key_code <= rx_byte;
			lane     <= pay_idx[1:0];
		end
	end

	// a byte finishing in idle would be lost
	a_no_byte_in_idle: assert property (@(posedge clk_mist) disable iff (rst)
		byte_done |-> state != st_idle);

	a_strobe_in_frame: assert property (@(posedge clk_mist) disable iff (rst)
		(status_we | buttons_we | joy0_we | joy1_we | key_strobe) |-> frame_active);

endmodule

/* user_io/spi_bit_counter.sv */
`timescale 1ns/100ps

module spi_bit_counter (
	input  logic                              clk_mist,
	input  logic                              rst,
	input  logic                              spi_sck,
	input  logic                              spi_ss,
	input  logic                              spi_di,
	output logic                              byte_done,
	output mist_ctrl_pkg::byte_t              rx_byte,
	output logic [mist_ctrl_pkg::idx_w-1:0]   byte_idx,
	output logic                              frame_active
);
	import mist_ctrl_pkg::*;

	logic [1:0] sck_sync;
	logic [1:0] ss_sync;
	logic [1:0] di_sync;
	logic       sck_d;
	logic       sck_rise;
	logic [2:0] bit_cnt;

	// two flop synchronizers on sck and ss
	always_ff @(posedge clk_mist) begin
		if (rst) begin
			sck_sync <= 2'b00;
			ss_sync  <= 2'b11; // deselected
			sck_d    <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], spi_sck};
			ss_sync  <= {ss_sync[0], spi_ss};
			sck_d    <= sck_sync[1];
		end
	end

	always_ff @(posedge clk_mist) begin
		di_sync <= {di_sync[0], spi_di};
	end

	assign sck_rise = sck_sync[1] & ~sck_d & ~ss_sync[1];

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			frame_active <= 1'b0;
			bit_cnt      <= '0;
			byte_done    <= 1'b0;
			byte_idx     <= '0;
		end else begin
			frame_active <= ~ss_sync[1]; // lines up with the sck path
			byte_done    <= sck_rise && bit_cnt == 3'd7;
			if (ss_sync[1]) begin
				bit_cnt  <= '0;
				byte_idx <= '0;
			end else begin
				if (sck_rise)
					bit_cnt <= bit_cnt + 3'd1;
				if (byte_done && byte_idx != idx_w'(max_payload_bytes + 1))
					byte_idx <= byte_idx + 1'b1; // saturates past last lane
			end
		end
	end

	always_ff @(posedge clk_mist) begin
		if (sck_rise)
			rx_byte <= {rx_byte[6:0], di_sync[1]}; // msb first
	end

	a_bitcnt_idle: assert property (@(posedge clk_mist) disable iff (rst)
		$fell(frame_active) |-> $past(bit_cnt) == 3'd0);

endmodule

/* common/mist_ctrl_pkg.sv */
package mist_ctrl_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] status_t;
	typedef logic [7:0]  joy_t;     // 0 right, 1 left, 2 down, 3 up, 4 fire, 5 bomb
	typedef logic [7:0]  buttons_t; // bit 1 board reset

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic one_player;
		logic two_players;
		logic fire1;
		logic fire2;
		logic fire3;
	} kbd_btn_t;

	// command codes
	localparam byte_t cmd_buttons = 8'h01;
	localparam byte_t cmd_joy0    = 8'h02;
	localparam byte_t cmd_joy1    = 8'h03;
	localparam byte_t cmd_ps2_kbd = 8'h04;
	localparam byte_t cmd_status  = 8'h1E;

	// ps/2 set 2 scancodes
	localparam byte_t sc_up    = 8'h75;
	localparam byte_t sc_down  = 8'h72;
	localparam byte_t sc_left  = 8'h6B;
	localparam byte_t sc_right = 8'h74;
	localparam byte_t sc_esc   = 8'h76;
	localparam byte_t sc_f1    = 8'h05;
	localparam byte_t sc_f2    = 8'h06;
	localparam byte_t sc_ctrl  = 8'h14;
	localparam byte_t sc_alt   = 8'h11;
	localparam byte_t sc_space = 8'h29;
	localparam byte_t sc_break = 8'hF0; // release prefix
	localparam byte_t sc_ext   = 8'hE0; // extended prefix, ignored

	localparam int status_rst_bit  = 0;
	localparam int status_rst2_bit = 6;
	localparam int scan_lo         = 3;
	localparam int scan_hi         = 4;
	localparam int btn_rst_bit     = 1;

	localparam int max_payload_bytes = 4;
	localparam int status_bytes      = 4;
	localparam int idx_w             = $clog2(max_payload_bytes + 2); // command + payload

endpackage
